//--- design/csr_counters.sv
// Cycle and retired-instruction counters, 64 bits wide, frozen while the pipeline stalls

`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_counters (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    active_i,
  input  logic                    trap_i,    // Trapping instruction does not retire
  input  csr_pkg::csr_req_t       req_i,
  output csr_pkg::counter_state_t state_o
);

  import csr_pkg::*;

  logic [`CSR_XLEN-1:0] mcycle_lo, mcycle_hi;
  logic [`CSR_XLEN-1:0] minstret_lo, minstret_hi;
  logic [63:0]          mcycle_inc, minstret_inc;
  logic                 wr_ok;      // Write not cancelled by a trap
  logic                 instret_wr, cycle_wr;
  logic                 instret_en;

  assign wr_ok        = req_i.wr_en && !trap_i;
  assign cycle_wr     = wr_ok && (req_i.addr == CSR_MCYCLE || req_i.addr == CSR_MCYCLEH);
  assign instret_wr   = wr_ok && (req_i.addr == CSR_MINSTRET || req_i.addr == CSR_MINSTRETH);
  assign instret_en   = !trap_i && !instret_wr;
  assign mcycle_inc   = {mcycle_hi, mcycle_lo} + 64'd1;
  assign minstret_inc = {minstret_hi, minstret_lo} + 64'd1;

  // Half write lands after the increment, so it wins for that half
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      mcycle_lo   <= '0;
      mcycle_hi   <= '0;
      minstret_lo <= '0;
      minstret_hi <= '0;
    end else if (active_i) begin
      {mcycle_hi, mcycle_lo} <= mcycle_inc;
      if (instret_en) {minstret_hi, minstret_lo} <= minstret_inc;
      if (wr_ok) begin
        unique case (req_i.addr)
          CSR_MCYCLE:    mcycle_lo   <= req_i.wdata;
          CSR_MCYCLEH:   mcycle_hi   <= req_i.wdata;
          CSR_MINSTRET:  minstret_lo <= req_i.wdata;
          CSR_MINSTRETH: minstret_hi <= req_i.wdata;
          default: ;  // User aliases are read only
        endcase
      end
    end
  end

  assign state_o = '{mcycle: {mcycle_hi, mcycle_lo}, minstret: {minstret_hi, minstret_lo}};

  // ====================
  // Assertions
  // ====================

  // Counting across one active cycle only moves mcycle up
  a_mcycle_mono: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (active_i && !cycle_wr) |=> (state_o.mcycle >= $past(state_o.mcycle))
  ) else $error("mcycle decreased without a write");

endmodule

//--- design/csr_file.sv
// Machine-mode CSR file top connecting the access port, trap inputs and register blocks

`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_file (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  csr_pkg::csr_req_t    req_i,
  input  csr_pkg::stall_e      stall_i,
  input  logic                 trap_i,        // One-cycle strobe
  input  logic                 mret_i,        // One-cycle strobe
  input  csr_pkg::trap_info_t  trap_info_i,
  input  csr_pkg::irq_t        irq_i,         // Levels
  output logic [`CSR_XLEN-1:0] csr_rdata_o,
  output logic [`CSR_XLEN-1:0] mtvec_o,
  output logic [`CSR_XLEN-1:0] mepc_o
);

  import csr_pkg::*;

  trap_state_t    trap_state;
  counter_state_t cnt_state;
  logic           active;

  // Trap overrides a stall so its state is always captured
  assign active = (stall_i == STALL_NONE) || trap_i;

  csr_trap_regs u_trap_regs (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .active_i    (active),
    .req_i       (req_i),
    .trap_i      (trap_i),
    .mret_i      (mret_i),
    .trap_info_i (trap_info_i),
    .state_o     (trap_state)
  );

  csr_counters u_counters (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .active_i (active),
    .trap_i   (trap_i),
    .req_i    (req_i),
    .state_o  (cnt_state)
  );

  csr_read_mux u_read_mux (
    .req_i   (req_i),
    .trap_i  (trap_state),
    .cnt_i   (cnt_state),
    .irq_i   (irq_i),
    .rdata_o (csr_rdata_o)
  );

  assign mtvec_o = trap_state.mtvec;  // Registered values
  assign mepc_o  = trap_state.mepc;

endmodule

//--- design/csr_pkg.sv
// CSR package with address and stall enums and the structs shared by the CSR blocks

`include "csr_settings.svh"

package csr_pkg;

  // ====================
  // Enums
  // ====================

  // Standard machine and user CSR addresses
  typedef enum logic [11:0] {
    CSR_MVENDORID  = 12'hF11,
    CSR_MARCHID    = 12'hF12,
    CSR_MIMPID     = 12'hF13,
    CSR_MHARTID    = 12'hF14,
    CSR_MCONFIGPTR = 12'hF15,
    CSR_MSTATUS    = 12'h300,
    CSR_MISA       = 12'h301,
    CSR_MIE        = 12'h304,
    CSR_MTVEC      = 12'h305,
    CSR_MCOUNTEREN = 12'h306,
    CSR_MSTATUSH   = 12'h310,
    CSR_MSCRATCH   = 12'h340,
    CSR_MEPC       = 12'h341,
    CSR_MCAUSE     = 12'h342,
    CSR_MTVAL      = 12'h343,
    CSR_MIP        = 12'h344,
    CSR_MCYCLE     = 12'hB00,
    CSR_MINSTRET   = 12'hB02,
    CSR_MCYCLEH    = 12'hB80,
    CSR_MINSTRETH  = 12'hB82,
    CSR_CYCLE      = 12'hC00,  // User aliases, read only
    CSR_INSTRET    = 12'hC02,
    CSR_CYCLEH     = 12'hC80,
    CSR_INSTRETH   = 12'hC82
  } csr_addr_e;

  typedef enum logic [2:0] {
    STALL_NONE,
    STALL_IMISS,   // Fetch miss
    STALL_DMISS,   // Load/store miss
    STALL_ALU,     // Multi-cycle op
    STALL_FENCEI
  } stall_e;

  // ====================
  // Structs
  // ====================

  typedef struct packed {
    logic       mie;
    logic       mpie;
    logic [1:0] mpp;   // Machine mode only
  } mstatus_t;

  typedef struct packed {
    logic                 rd_en;
    logic                 wr_en;
    csr_addr_e            addr;
    logic [`CSR_XLEN-1:0] wdata;
  } csr_req_t;

  // Saved at trap entry
  typedef struct packed {
    logic [`CSR_XLEN-1:0] epc;
    logic [`CSR_XLEN-1:0] cause;
    logic [`CSR_XLEN-1:0] tval;
  } trap_info_t;

  // Interrupt request levels
  typedef struct packed {
    logic msip;
    logic mtip;
    logic meip;
  } irq_t;

  typedef struct packed {
    mstatus_t             mstatus;
    logic [`CSR_XLEN-1:0] mie;
    logic [`CSR_XLEN-1:0] mtvec;
    logic [`CSR_XLEN-1:0] mscratch;
    logic [`CSR_XLEN-1:0] mepc;
    logic [`CSR_XLEN-1:0] mcause;
    logic [`CSR_XLEN-1:0] mtval;
  } trap_state_t;

  typedef struct packed {
    logic [63:0] mcycle;
    logic [63:0] minstret;
  } counter_state_t;

endpackage

//--- design/csr_read_mux.sv
// CSR read decode for trap registers, counters, pending bits and identification constants

`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_read_mux (
  input  csr_pkg::csr_req_t       req_i,
  input  csr_pkg::trap_state_t    trap_i,
  input  csr_pkg::counter_state_t cnt_i,
  input  csr_pkg::irq_t           irq_i,
  output logic [`CSR_XLEN-1:0]    rdata_o
);

  import csr_pkg::*;

  logic [`CSR_XLEN-1:0] mstatus_word;
  logic [`CSR_XLEN-1:0] mip_word;

  // Packed register images
  always_comb begin
    mstatus_word        = '0;
    mstatus_word[3]     = trap_i.mstatus.mie;
    mstatus_word[7]     = trap_i.mstatus.mpie;
    mstatus_word[12:11] = trap_i.mstatus.mpp;

    mip_word     = '0;
    mip_word[3]  = irq_i.msip;   // Software
    mip_word[7]  = irq_i.mtip;   // Timer
    mip_word[11] = irq_i.meip;   // External
  end

  // ====================
  // Address decode
  // ====================

  always_comb begin
    rdata_o = '0;
    if (req_i.rd_en) begin
      unique case (req_i.addr)
        CSR_MARCHID:  rdata_o = `CSR_MARCHID;
        CSR_MISA:     rdata_o = `CSR_MISA_VALUE;
        CSR_MSTATUS:  rdata_o = mstatus_word;
        CSR_MIE:      rdata_o = trap_i.mie;
        CSR_MTVEC:    rdata_o = trap_i.mtvec;
        CSR_MSCRATCH: rdata_o = trap_i.mscratch;
        CSR_MEPC:     rdata_o = trap_i.mepc;
        CSR_MCAUSE:   rdata_o = trap_i.mcause;
        CSR_MTVAL:    rdata_o = trap_i.mtval;
        CSR_MIP:      rdata_o = mip_word;
        // Machine counters and their user aliases
        CSR_MCYCLE,    CSR_CYCLE:    rdata_o = cnt_i.mcycle[31:0];
        CSR_MCYCLEH,   CSR_CYCLEH:   rdata_o = cnt_i.mcycle[63:32];
        CSR_MINSTRET,  CSR_INSTRET:  rdata_o = cnt_i.minstret[31:0];
        CSR_MINSTRETH, CSR_INSTRETH: rdata_o = cnt_i.minstret[63:32];
        // Read-only zero
        CSR_MVENDORID, CSR_MIMPID, CSR_MHARTID, CSR_MCONFIGPTR,
        CSR_MCOUNTEREN, CSR_MSTATUSH: rdata_o = '0;
        default: rdata_o = '0;  // Unknown address
      endcase
    end
  end

endmodule

//--- design/csr_settings.svh
// CSR file settings with data width, write masks and constant register values

`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

// ====================
// Widths
// ====================

`define CSR_XLEN 32

// ====================
// Masks and constants
// ====================

// Writable mie bits, MSIE MTIE MEIE
`define CSR_MIE_MASK 32'h0000_0888

// RV32IMC, MXL = 1
`define CSR_MISA_VALUE 32'h4000_1104

`define CSR_MARCHID 32'd5

// MPP = 11, both enables clear
`define CSR_MSTATUS_RESET 32'h0000_1800

`endif

//--- design/csr_trap_regs.sv
// Machine trap setup and handling registers with trap entry, mret and masked writes

`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_trap_regs (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 active_i,     // Pipeline not stalled, or trap taken
  input  csr_pkg::csr_req_t    req_i,
  input  logic                 trap_i,
  input  logic                 mret_i,
  input  csr_pkg::trap_info_t  trap_info_i,
  output csr_pkg::trap_state_t state_o
);

  import csr_pkg::*;

  localparam logic [`CSR_XLEN-1:0] MSTATUS_RST = `CSR_MSTATUS_RESET;

  // ====================
  // Registers
  // ====================

  mstatus_t             mstatus_q;
  logic [`CSR_XLEN-1:0] mie_q;
  logic [`CSR_XLEN-1:0] mtvec_q;
  logic [`CSR_XLEN-1:0] mscratch_q;
  logic [`CSR_XLEN-1:0] mepc_q;
  logic [`CSR_XLEN-1:0] mcause_q;
  logic [`CSR_XLEN-1:0] mtval_q;

  // Priority: trap, then mret, then software write
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      mstatus_q  <= '{mie: MSTATUS_RST[3], mpie: MSTATUS_RST[7], mpp: MSTATUS_RST[12:11]};
      mie_q      <= '0;
      mtvec_q    <= '0;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
      mtval_q    <= '0;
    end else if (active_i) begin
      if (trap_i) begin
        // Trap entry
        mepc_q         <= trap_info_i.epc;
        mcause_q       <= trap_info_i.cause;
        mtval_q        <= trap_info_i.tval;
        mstatus_q.mpie <= mstatus_q.mie;   // Save enable
        mstatus_q.mie  <= 1'b0;            // Handler runs with irqs off
        mstatus_q.mpp  <= 2'b11;
      end else if (mret_i) begin
        mstatus_q.mie  <= mstatus_q.mpie;  // Restore enable
        mstatus_q.mpie <= 1'b1;
        mstatus_q.mpp  <= 2'b11;
      end else if (req_i.wr_en) begin
        unique case (req_i.addr)
          // Only mie/mpie writable, MPP fixed at M
          CSR_MSTATUS:  mstatus_q  <= '{mie: req_i.wdata[3], mpie: req_i.wdata[7], mpp: 2'b11};
          CSR_MIE:      mie_q      <= req_i.wdata & `CSR_MIE_MASK;
          CSR_MTVEC:    mtvec_q    <= req_i.wdata;
          CSR_MSCRATCH: mscratch_q <= req_i.wdata;
          CSR_MEPC:     mepc_q     <= req_i.wdata;
          CSR_MCAUSE:   mcause_q   <= req_i.wdata;
          CSR_MTVAL:    mtval_q    <= req_i.wdata;
          default: ;  // Read-only, counters or unknown
        endcase
      end
    end
  end

  // ====================
  // Outputs
  // ====================

  assign state_o = '{
    mstatus:  mstatus_q,
    mie:      mie_q,
    mtvec:    mtvec_q,
    mscratch: mscratch_q,
    mepc:     mepc_q,
    mcause:   mcause_q,
    mtval:    mtval_q
  };

  // ====================
  // Assertions
  // ====================

  // No other privilege mode exists, so trap return always goes to M
  a_mpp_machine: assert property (
    @(posedge clk_i) disable iff (!rst_ni) mstatus_q.mpp == 2'b11
  ) else $error("mstatus.mpp left machine mode");

  // Pipeline never retires mret in the cycle it takes a trap
  a_trap_mret_excl: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !(trap_i && mret_i)
  ) else $error("trap and mret strobes high together");

endmodule

//--- project.f
+incdir+design
design/csr_pkg.sv
design/csr_trap_regs.sv
design/csr_counters.sv
design/csr_read_mux.sv
design/csr_file.sv
sim/tb_csr_file.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the CSR file testbench with Verilator
verilator --binary --timing --assert -f project.f --top-module tb_csr_file -o tb_csr_file \
  && ./obj_dir/tb_csr_file \
  || exit 1

//--- sim/tb_csr_file.sv
// Testbench for the CSR file with a reference model, random stimulus and per-cycle checks

`timescale 1ns/1ps
`include "csr_settings.svh"

module tb_csr_file;

  import csr_pkg::*;

  logic                 clk_i, rst_ni, trap, mret;
  csr_req_t             req;
  stall_e               stall;
  trap_info_t           info;
  irq_t                 irq;
  logic [`CSR_XLEN-1:0] rdata, mtvec, mepc;
  trap_state_t          ref_trap;   // Reference model state
  counter_state_t       ref_cnt;
  logic [31:0]          rng = 32'h71ff_a7e1;
  logic [31:0]          r;
  int                   cycles_driven = 0;
  int                   check_count = 0;
  int                   waited;
  int                   idx;

  // Ids and zero regs, writable trap regs, counters and aliases
  logic [11:0] addr_tab [26] = '{12'hF11, 12'hF12, 12'hF13, 12'hF14, 12'hF15, 12'h301,
    12'h7C0, 12'h123, 12'h306, 12'h310, 12'h300, 12'h304, 12'h305, 12'h340, 12'h341,
    12'h342, 12'h343, 12'h344, 12'hB00, 12'hB02, 12'hB80, 12'hB82, 12'hC00, 12'hC02,
    12'hC80, 12'hC82};

  csr_file u_csr_file (.clk_i(clk_i), .rst_ni(rst_ni), .req_i(req), .stall_i(stall),
    .trap_i(trap), .mret_i(mret), .trap_info_i(info), .irq_i(irq), .csr_rdata_o(rdata),
    .mtvec_o(mtvec), .mepc_o(mepc));

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;  // 20 ns period
  end

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // ====================
  // Reference model
  // ====================

  function automatic void advance_model();
    logic cw;
    logic ins_wr;
    cw     = req.wr_en && !trap;  // Trap cancels the write
    ins_wr = cw && (req.addr == CSR_MINSTRET || req.addr == CSR_MINSTRETH);
    if (stall == STALL_NONE || trap) begin
      if (trap) begin
        ref_trap.mepc         = info.epc;
        ref_trap.mcause       = info.cause;
        ref_trap.mtval        = info.tval;
        ref_trap.mstatus.mpie = ref_trap.mstatus.mie;
        ref_trap.mstatus.mie  = 1'b0;
      end else if (mret) begin
        ref_trap.mstatus.mie  = ref_trap.mstatus.mpie;
        ref_trap.mstatus.mpie = 1'b1;
      end else if (req.wr_en) begin
        case (req.addr)
          CSR_MSTATUS:  ref_trap.mstatus = '{mie: req.wdata[3], mpie: req.wdata[7], mpp: 2'b11};
          CSR_MIE:      ref_trap.mie = {20'd0, req.wdata[11], 3'd0, req.wdata[7], 3'd0,
                                        req.wdata[3], 3'd0};  // MEIE MTIE MSIE only
          CSR_MTVEC:    ref_trap.mtvec = req.wdata;
          CSR_MSCRATCH: ref_trap.mscratch = req.wdata;
          CSR_MEPC:     ref_trap.mepc = req.wdata;
          CSR_MCAUSE:   ref_trap.mcause = req.wdata;
          CSR_MTVAL:    ref_trap.mtval = req.wdata;
          default: ;
        endcase
      end
      ref_cnt.mcycle = ref_cnt.mcycle + 64'd1;
      if (!trap && !ins_wr) ref_cnt.minstret = ref_cnt.minstret + 64'd1;
      if (cw) begin
        case (req.addr)
          CSR_MCYCLE:    ref_cnt.mcycle[31:0] = req.wdata;    // On top of the increment
          CSR_MCYCLEH:   ref_cnt.mcycle[63:32] = req.wdata;
          CSR_MINSTRET:  ref_cnt.minstret[31:0] = req.wdata;
          CSR_MINSTRETH: ref_cnt.minstret[63:32] = req.wdata;
          default: ;
        endcase
      end
    end
  endfunction

  function automatic logic [`CSR_XLEN-1:0] expected_read();
    logic [`CSR_XLEN-1:0] d;
    d = '0;
    if (req.rd_en) begin
      case (req.addr)
        CSR_MSTATUS: d = {19'd0, ref_trap.mstatus.mpp, 3'd0, ref_trap.mstatus.mpie, 3'd0,
                          ref_trap.mstatus.mie, 3'd0};
        CSR_MISA:     d = `CSR_MISA_VALUE;
        CSR_MARCHID:  d = `CSR_MARCHID;
        CSR_MIE:      d = ref_trap.mie;
        CSR_MTVEC:    d = ref_trap.mtvec;
        CSR_MSCRATCH: d = ref_trap.mscratch;
        CSR_MEPC:     d = ref_trap.mepc;
        CSR_MCAUSE:   d = ref_trap.mcause;
        CSR_MTVAL:    d = ref_trap.mtval;
        CSR_MIP:      d = {20'd0, irq.meip, 3'd0, irq.mtip, 3'd0, irq.msip, 3'd0};
        CSR_MCYCLE, CSR_CYCLE:       d = ref_cnt.mcycle[31:0];
        CSR_MCYCLEH, CSR_CYCLEH:     d = ref_cnt.mcycle[63:32];
        CSR_MINSTRET, CSR_INSTRET:   d = ref_cnt.minstret[31:0];
        CSR_MINSTRETH, CSR_INSTRETH: d = ref_cnt.minstret[63:32];
        default: d = '0;  // Ids, zero regs, unknown
      endcase
    end
    return d;
  endfunction

  // ====================
  // Checks
  // ====================

  task automatic check_data(input logic [`CSR_XLEN-1:0] got, input logic [`CSR_XLEN-1:0] exp,
                            input string what);
    if (got !== exp) begin
      $display("mismatch at time %0t: %s, got %08h expected %08h", $time, what, got, exp);
      $display("** FAIL **");
      $fatal(1, "read data check failed");
    end
  endtask

  task automatic check_trap_outputs(input logic [`CSR_XLEN-1:0] mtvec_got,
                                    input logic [`CSR_XLEN-1:0] mepc_got,
                                    input trap_state_t exp);
    if (mtvec_got !== exp.mtvec || mepc_got !== exp.mepc) begin
      $display("mismatch at time %0t: mtvec_o %08h mepc_o %08h, expected %08h %08h",
               $time, mtvec_got, mepc_got, exp.mtvec, exp.mepc);
      $display("** FAIL **");
      $fatal(1, "trap output check failed");
    end
  endtask

  // Falling edge sits between input changes and register updates
  always @(negedge clk_i) begin
    if (rst_ni !== 1'b1) begin
      ref_trap             = '0;
      ref_trap.mstatus.mpp = 2'b11;
      ref_cnt              = '0;
    end else begin
      check_data(rdata, expected_read(), $sformatf("read of csr %03h", req.addr));
      check_trap_outputs(mtvec, mepc, ref_trap);
      advance_model();
      check_count++;
    end
  end

  // One cycle of stimulus with random write data and trap info
  task automatic step(input logic [11:0] ad, input logic rd, input logic wr, input stall_e s,
                      input logic t, input logic m);
    logic [31:0] d;
    d = next_rand();
    if (ad == 12'hB80) d[31] = 1'b0;  // Keep mcycle far from wrap
    req   = '{rd_en: rd, wr_en: wr, addr: csr_addr_e'(ad), wdata: d};
    stall = s;
    trap  = t;
    mret  = m;
    info  = '{epc: next_rand(), cause: next_rand(), tval: next_rand()};
    @(posedge clk_i);
    #2;
    cycles_driven++;
  endtask

  initial begin
    rst_ni = 1'b0;
    req    = '0;
    stall  = STALL_NONE;
    trap   = 1'b0;
    mret   = 1'b0;
    info   = '0;
    irq    = '0;
    repeat (16) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    for (int i = 0; i <= 10; i++) step(addr_tab[i], 1'b1, 1'b0, STALL_NONE, 1'b0, 1'b0);
    // Each write including the ignored ones is read back next cycle
    for (int i = 5; i <= 16; i++) begin
      step(addr_tab[i], 1'b1, 1'b1, STALL_NONE, 1'b0, 1'b0);
      step(addr_tab[i], 1'b1, 1'b0, STALL_NONE, 1'b0, 1'b0);
    end
    step(12'h300, 1'b1, 1'b1, STALL_NONE, 1'b0, 1'b0);
    step(12'h341, 1'b1, 1'b1, STALL_DMISS, 1'b1, 1'b0);  // Trap under stall beats write
    for (int i = 10; i <= 16; i++) step(addr_tab[i], 1'b1, 1'b0, STALL_NONE, 1'b0, 1'b0);
    step(12'h300, 1'b1, 1'b1, STALL_NONE, 1'b0, 1'b1);   // mret beats write
    step(12'h300, 1'b1, 1'b0, STALL_NONE, 1'b0, 1'b0);
    repeat (20) begin
      r   = next_rand();
      irq = r[2:0];
      step(12'h344, 1'b1, 1'b0, STALL_NONE, 1'b0, 1'b0);
    end
    repeat (8) step(12'hB00, 1'b1, 1'b0, STALL_IMISS, 1'b0, 1'b0);  // Frozen
    step(12'hB02, 1'b1, 1'b0, STALL_ALU, 1'b1, 1'b0);
    for (int i = 18; i <= 21; i++) step(addr_tab[i], 1'b1, 1'b1, STALL_NONE, 1'b0, 1'b0);
    for (int i = 18; i <= 25; i++) step(addr_tab[i], 1'b1, 1'b0, STALL_NONE, 1'b0, 1'b0);
    // Random mix
    for (int n = 0; n < 3000; n++) begin
      r   = next_rand();
      irq = r[2:0];
      idx = r % 26;
      step(addr_tab[idx], r[3] | r[4], r[5], (r[25:24] != 2'd0) ? STALL_NONE :
           stall_e'({1'b0, r[27:26]} + 3'd1), r[19:16] == 4'd0,
           r[19:16] != 4'd0 && r[23:20] == 4'd0);
    end
    step(12'h300, 1'b0, 1'b0, STALL_NONE, 1'b0, 1'b0);
    waited = 0;
    while (check_count < cycles_driven && waited < 50) begin
      @(negedge clk_i);
      waited++;
    end
    if (check_count >= cycles_driven) begin
      $display("** PASS **");
      $finish;
    end else begin
      $display("compare process did not check every driven cycle");
      $display("** FAIL **");
      $fatal(1, "timeout waiting for checks");
    end
  end

endmodule
